// ==== flist.f ====
verilog/epu_msr_pkg.sv
verilog/epu_isa_pkg.sv
verilog/msr_decode.sv
verilog/msr_readout.sv
verilog/commit_unit.sv
verilog/msr_file.sv
verilog/epu_top.sv
tb/epu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the EPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module epu_tb -f flist.f -o epu_sim

./obj_dir/epu_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// ==== tb/epu_tb.sv ====
/*
 * Testbench for the exception and MSR unit
 * Clock, reset, issue and commit stimulus, shadow MSR model
 * Concurrent checks on the writeback record, watchdog, report
 */

`timescale 1ns/1ns

module epu_tb;

   localparam int clk_period = 100;
   // Reset plus the cycles of each test
   localparam int run_cycles = 10 + 5 + 8 + 23 + 8 + 20 + 10;

   localparam epu_msr_pkg::data_t syscall_vec = 32'h0000_0c00;
   localparam epu_msr_pkg::data_t eitm_vec    = 32'h0000_0a04;
   localparam epu_msr_pkg::data_t eipf_vec    = 32'h0000_0b08;
   localparam epu_msr_pkg::data_t einsn_vec   = 32'h0000_070c;
   localparam epu_msr_pkg::data_t eirq_vec    = 32'h0000_0810;
   localparam epu_msr_pkg::data_t core_id     = 32'h0000_0003;

   localparam epu_isa_pkg::msr_addr_t a_psr =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_psr};
   localparam epu_isa_pkg::msr_addr_t a_cpuid =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_cpuid};
   localparam epu_isa_pkg::msr_addr_t a_epsr =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_epsr};
   localparam epu_isa_pkg::msr_addr_t a_epc =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_epc};
   localparam epu_isa_pkg::msr_addr_t a_elsa =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_elsa};
   localparam epu_isa_pkg::msr_addr_t a_coreid =
      {epu_isa_pkg::bank_ps, 9'b1 << epu_isa_pkg::off_coreid};
   localparam epu_isa_pkg::msr_addr_t a_imr =
      {epu_isa_pkg::bank_irqc, 9'b1 << epu_isa_pkg::off_imr};
   localparam epu_isa_pkg::msr_addr_t a_irr =
      {epu_isa_pkg::bank_irqc, 9'b1 << epu_isa_pkg::off_irr};
   localparam epu_isa_pkg::msr_addr_t a_tsr =
      {epu_isa_pkg::bank_tsc, 9'b1 << epu_isa_pkg::off_tsr};
   localparam epu_isa_pkg::msr_addr_t a_tcr =
      {epu_isa_pkg::bank_tsc, 9'b1 << epu_isa_pkg::off_tcr};
   localparam epu_isa_pkg::msr_addr_t a_unknown = {4'd3, 9'h001};

   localparam epu_isa_pkg::msr_addr_t rw_regs [6] = '{a_epc, a_elsa, a_epsr, a_imr, a_tsr,
                                                      a_tcr};
   localparam epu_isa_pkg::epu_op_e trap_ops [6] = '{
      epu_isa_pkg::op_syscall, epu_isa_pkg::op_eret, epu_isa_pkg::op_eitm,
      epu_isa_pkg::op_eipf, epu_isa_pkg::op_eirq, epu_isa_pkg::op_einsn};
   localparam epu_isa_pkg::exc_kind_e entry_kinds [4] = '{
      epu_isa_pkg::exc_syscall, epu_isa_pkg::exc_eitm, epu_isa_pkg::exc_edtm,
      epu_isa_pkg::exc_ealign};

   logic                   clk;
   logic                   rst_n;
   logic                   issue_valid;
   epu_msr_pkg::pc_t       issue_pc;
   epu_isa_pkg::epu_op_e   issue_op;
   epu_msr_pkg::data_t     operand1;
   epu_msr_pkg::data_t     operand2;
   epu_msr_pkg::data_t     imm;
   epu_msr_pkg::data_t     irr;
   epu_isa_pkg::commit_t   commit;
   epu_isa_pkg::wb_t       wb;

   // Expected writeback staged like the DUT register
   epu_isa_pkg::wb_t       nxt_wb;
   epu_isa_pkg::wb_t       exp_wb;
   epu_isa_pkg::commit_t   pend;
   epu_msr_pkg::msr_view_t sh;
   epu_msr_pkg::pc_t       pc_next;
   epu_msr_pkg::data_t     rnd;
   integer                 seed;
   int                     err_cnt;
   int                     err_mark;
   int                     test_cnt;

   epu_top #(
      .syscall_vector (syscall_vec),
      .eitm_vector    (eitm_vec),
      .eipf_vector    (eipf_vec),
      .einsn_vector   (einsn_vec),
      .eirq_vector    (eirq_vec),
      .core_id        (core_id)
   ) dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_pc    (issue_pc),
      .issue_op    (issue_op),
      .operand1    (operand1),
      .operand2    (operand2),
      .imm         (imm),
      .irr         (irr),
      .commit      (commit),
      .wb          (wb)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      exp_wb <= nxt_wb;
   end

   valid_check: assert property (@(posedge clk) disable iff (!rst_n)
      wb.valid == exp_wb.valid)
   else begin
      err_cnt++;
      $display("Fail at %0t: wb.valid %0b, expected %0b", $time,
               $sampled(wb.valid), $sampled(exp_wb.valid));
   end

   pc_check: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.valid |-> wb.pc == exp_wb.pc)
   else begin
      err_cnt++;
      $display("Fail at %0t: wb.pc 0x%08h, expected 0x%08h", $time,
               $sampled(wb.pc), $sampled(exp_wb.pc));
   end

   dout_check: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.valid |-> wb.dout == exp_wb.dout)
   else begin
      err_cnt++;
      $display("Fail at %0t: wb.dout 0x%08h, expected 0x%08h", $time,
               $sampled(wb.dout), $sampled(exp_wb.dout));
   end

   trap_check: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.valid |-> wb.exc == exp_wb.exc && wb.exc_vec == exp_wb.exc_vec)
   else begin
      err_cnt++;
      $display("Fail at %0t: wb.exc %0d vec 0x%08h, expected %0d vec 0x%08h", $time,
               $sampled(wb.exc), $sampled(wb.exc_vec), $sampled(exp_wb.exc),
               $sampled(exp_wb.exc_vec));
   end

   write_check: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.valid |-> wb.wmsr_we == exp_wb.wmsr_we && wb.wmsr_dat == exp_wb.wmsr_dat)
   else begin
      err_cnt++;
      $display("Fail at %0t: wb.wmsr_we 0x%02h dat 0x%08h, expected 0x%02h dat 0x%08h",
               $time, $sampled(wb.wmsr_we), $sampled(wb.wmsr_dat),
               $sampled(exp_wb.wmsr_we), $sampled(exp_wb.wmsr_dat));
   end

   // Register value as software sees it
   function automatic epu_msr_pkg::data_t model_read(input epu_isa_pkg::msr_addr_t a);
      case (a)
         a_psr:    model_read = {22'b0, sh.psr};
         a_cpuid:  model_read = epu_msr_pkg::cpuid_value;
         a_epsr:   model_read = {22'b0, sh.epsr};
         a_epc:    model_read = sh.epc;
         a_elsa:   model_read = sh.elsa;
         a_coreid: model_read = core_id;
         a_imr:    model_read = sh.imr;
         a_irr:    model_read = irr;
         a_tsr:    model_read = sh.tsr;
         a_tcr:    model_read = sh.tcr;
         default:  model_read = '0;
      endcase
   endfunction

   function automatic epu_msr_pkg::msr_we_t reg_we(input epu_isa_pkg::msr_addr_t a);
      epu_msr_pkg::msr_we_t w;
      w = '0;
      case (a)
         a_psr:   w.psr = 1'b1;
         a_epc:   w.epc = 1'b1;
         a_epsr:  w.epsr = 1'b1;
         a_elsa:  w.elsa = 1'b1;
         a_imr:   w.imr = 1'b1;
         a_tsr:   w.tsr = 1'b1;
         a_tcr:   w.tcr = 1'b1;
         default: w = '0;
      endcase
      reg_we = w;
   endfunction

   function automatic epu_isa_pkg::exc_kind_e trap_kind(input epu_isa_pkg::epu_op_e op);
      case (op)
         epu_isa_pkg::op_syscall: trap_kind = epu_isa_pkg::exc_syscall;
         epu_isa_pkg::op_eret:    trap_kind = epu_isa_pkg::exc_eret;
         epu_isa_pkg::op_eitm:    trap_kind = epu_isa_pkg::exc_eitm;
         epu_isa_pkg::op_eipf:    trap_kind = epu_isa_pkg::exc_eipf;
         epu_isa_pkg::op_eirq:    trap_kind = epu_isa_pkg::exc_eirq;
         epu_isa_pkg::op_einsn:   trap_kind = epu_isa_pkg::exc_einsn;
         default:                 trap_kind = epu_isa_pkg::exc_none;
      endcase
   endfunction

   function automatic epu_msr_pkg::pc_t trap_vec(input epu_isa_pkg::epu_op_e op);
      case (op)
         epu_isa_pkg::op_syscall: trap_vec = syscall_vec[31:2];
         epu_isa_pkg::op_eret:    trap_vec = sh.epc[31:2];
         epu_isa_pkg::op_eitm:    trap_vec = eitm_vec[31:2];
         epu_isa_pkg::op_eipf:    trap_vec = eipf_vec[31:2];
         epu_isa_pkg::op_eirq:    trap_vec = eirq_vec[31:2];
         epu_isa_pkg::op_einsn:   trap_vec = einsn_vec[31:2];
         default:                 trap_vec = '0;
      endcase
   endfunction

   // Mode bits from src with reserved bits kept
   function automatic epu_msr_pkg::psr_t take_mode(input epu_msr_pkg::psr_t keep,
                                                   input epu_msr_pkg::psr_t src);
      take_mode      = keep;
      take_mode.rm   = src.rm;
      take_mode.ire  = src.ire;
      take_mode.imme = src.imme;
      take_mode.dmme = src.dmme;
   endfunction

   // Shadow MSR update by the commit rules
   task automatic apply_commit(input epu_isa_pkg::commit_t c);
      epu_msr_pkg::msr_view_t o;
      epu_msr_pkg::psr_t      wp;
      logic                   entry;
      o     = sh;
      wp    = epu_msr_pkg::psr_t'(c.wmsr_dat[9:0]);
      entry = c.exc != epu_isa_pkg::exc_none && c.exc != epu_isa_pkg::exc_eret;
      if (c.valid) begin
         if (c.wmsr_we.psr) sh.psr = take_mode(o.psr, wp);
         if (c.exc == epu_isa_pkg::exc_eret) sh.psr = take_mode(o.psr, o.epsr);
         if (c.wmsr_we.epsr) sh.epsr = wp;
         if (entry) sh.epsr = o.psr;
         if (c.wmsr_we.epc) sh.epc = c.wmsr_dat;
         if (entry) begin
            sh.epc = (c.exc == epu_isa_pkg::exc_syscall) ? {c.pc + 30'd1, 2'b00} : {c.pc, 2'b00};
         end
         case (c.exc)
            epu_isa_pkg::exc_eitm, epu_isa_pkg::exc_eipf, epu_isa_pkg::exc_einsn:
               sh.elsa = {c.pc, 2'b00};
            epu_isa_pkg::exc_edtm, epu_isa_pkg::exc_edpf, epu_isa_pkg::exc_ealign:
               sh.elsa = c.lsa;
            default: if (c.wmsr_we.elsa) sh.elsa = c.wmsr_dat;
         endcase
         if (c.wmsr_we.imr) sh.imr = c.wmsr_dat;
         if (c.wmsr_we.tsr) sh.tsr = c.wmsr_dat;
         if (c.wmsr_we.tcr) sh.tcr = c.wmsr_dat;
      end
   endtask

   task automatic idle();
      @(negedge clk);
      issue_valid = 1'b0;
      commit      = '0;
      nxt_wb      = '0;
   endtask

   // Address split at random between operand1 and imm
   task automatic do_issue(input epu_isa_pkg::epu_op_e op, input epu_isa_pkg::msr_addr_t a,
                           input epu_msr_pkg::data_t d);
      epu_msr_pkg::data_t mask;
      epu_msr_pkg::data_t upper;
      mask  = $random(seed);
      upper = $random(seed);
      @(negedge clk);
      issue_valid = 1'b1;
      issue_pc    = pc_next;
      issue_op    = op;
      operand1    = {upper[31:13], a & mask[12:0]};
      imm         = {mask[31:13], a & ~mask[12:0]};
      operand2    = d;
      commit      = '0;
      nxt_wb          = '0;
      nxt_wb.valid    = 1'b1;
      nxt_wb.pc       = pc_next;
      nxt_wb.dout     = (op == epu_isa_pkg::op_rmsr) ? model_read(a) : '0;
      nxt_wb.exc      = trap_kind(op);
      nxt_wb.exc_vec  = trap_vec(op);
      nxt_wb.wmsr_we  = (op == epu_isa_pkg::op_wmsr) ? reg_we(a) : '0;
      nxt_wb.wmsr_dat = d;
      pend          = '0;
      pend.valid    = 1'b1;
      pend.pc       = pc_next;
      pend.exc      = nxt_wb.exc;
      pend.wmsr_we  = nxt_wb.wmsr_we;
      pend.wmsr_dat = d;
      pc_next = pc_next + 30'd1;
   endtask

   // Retire the last writeback through the commit port
   task automatic feed_back();
      @(negedge clk);
      issue_valid = 1'b0;
      nxt_wb      = '0;
      while (!wb.valid) @(negedge clk);
      commit          = '0;
      commit.valid    = 1'b1;
      commit.pc       = wb.pc;
      commit.exc      = wb.exc;
      commit.wmsr_we  = wb.wmsr_we;
      commit.wmsr_dat = wb.wmsr_dat;
      apply_commit(pend);
   endtask

   task automatic commit_exc(input epu_isa_pkg::exc_kind_e kind, input epu_msr_pkg::data_t lsa);
      @(negedge clk);
      issue_valid  = 1'b0;
      nxt_wb       = '0;
      commit       = '0;
      commit.valid = 1'b1;
      commit.pc    = pc_next;
      commit.exc   = kind;
      commit.lsa   = lsa;
      apply_commit(commit);
      pc_next = pc_next + 30'd1;
   endtask

   // Drain so the last writeback is checked
   task automatic end_test(input string name);
      idle();
      idle();
      test_cnt++;
      $display("test %0d %s: %0d failed checks", test_cnt, name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin
      #((run_cycles + 100) * clk_period);
      $display("Timeout: the tests did not finish in time");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      seed        = 32'h5e7a;
      rst_n       = 1'b0;
      issue_valid = 1'b0;
      issue_pc    = '0;
      issue_op    = epu_isa_pkg::op_rmsr;
      operand1    = '0;
      operand2    = '0;
      imm         = '0;
      irr         = '0;
      commit      = '0;
      nxt_wb      = '0;
      pend        = '0;
      pc_next     = 30'h100;
      rnd         = '0;
      err_cnt     = 0;
      err_mark    = 0;
      test_cnt    = 0;
      sh          = '0;
      sh.psr      = epu_msr_pkg::psr_reset;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      idle();
      do_issue(epu_isa_pkg::op_rmsr, a_psr, $random(seed));
      do_issue(epu_isa_pkg::op_rmsr, a_cpuid, $random(seed));
      end_test("reset values");

      idle();
      irr = $random(seed);
      do_issue(epu_isa_pkg::op_rmsr, a_coreid, $random(seed));
      do_issue(epu_isa_pkg::op_rmsr, a_irr, $random(seed));
      do_issue(epu_isa_pkg::op_wmsr, a_imr, $random(seed));
      do_issue(epu_isa_pkg::op_rmsr, a_tcr, $random(seed));
      do_issue(epu_isa_pkg::op_rmsr, a_unknown, $random(seed));
      end_test("back to back issue");

      for (int i = 0; i < 6; i++) begin
         do_issue(epu_isa_pkg::op_wmsr, rw_regs[i], $random(seed));
         feed_back();
         do_issue(epu_isa_pkg::op_rmsr, rw_regs[i], $random(seed));
      end
      // CPUID is read only
      do_issue(epu_isa_pkg::op_wmsr, a_cpuid, $random(seed));
      feed_back();
      do_issue(epu_isa_pkg::op_rmsr, a_cpuid, $random(seed));
      end_test("write and read back");

      for (int i = 0; i < 6; i++) begin
         do_issue(trap_ops[i], '0, $random(seed));
      end
      end_test("trap vectors");

      do_issue(epu_isa_pkg::op_wmsr, a_psr, $random(seed));
      feed_back();
      for (int i = 0; i < 4; i++) begin
         commit_exc(entry_kinds[i], $random(seed));
         do_issue(epu_isa_pkg::op_rmsr, a_epc, $random(seed));
         do_issue(epu_isa_pkg::op_rmsr, a_epsr, $random(seed));
         do_issue(epu_isa_pkg::op_rmsr, a_elsa, $random(seed));
      end
      end_test("exception entry");

      rnd = $random(seed);
      do_issue(epu_isa_pkg::op_wmsr, a_epsr, rnd);
      feed_back();
      // Opposite mode bits so the return has to change PSR
      do_issue(epu_isa_pkg::op_wmsr, a_psr, ~rnd);
      feed_back();
      do_issue(epu_isa_pkg::op_eret, '0, $random(seed));
      feed_back();
      do_issue(epu_isa_pkg::op_rmsr, a_psr, $random(seed));
      do_issue(epu_isa_pkg::op_rmsr, a_epsr, $random(seed));
      end_test("return from exception");

      $display("%0d tests run, %0d failed checks", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verilog/epu_top.sv ====
/*
 * Exception and MSR unit top level
 * Issue decode, MSR readout, commit update and MSR registers
 */

`timescale 1ns/1ns

module epu_top #(
   parameter epu_msr_pkg::data_t syscall_vector = 32'h0000_0100,
   parameter epu_msr_pkg::data_t eitm_vector    = 32'h0000_0200,
   parameter epu_msr_pkg::data_t eipf_vector    = 32'h0000_0300,
   parameter epu_msr_pkg::data_t einsn_vector   = 32'h0000_0400,
   parameter epu_msr_pkg::data_t eirq_vector    = 32'h0000_0500,
   parameter epu_msr_pkg::data_t core_id        = 32'h0000_0000
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 issue_valid,
   input  epu_msr_pkg::pc_t     issue_pc,
   input  epu_isa_pkg::epu_op_e issue_op,
   input  epu_msr_pkg::data_t   operand1,
   input  epu_msr_pkg::data_t   operand2,
   input  epu_msr_pkg::data_t   imm,
   input  epu_msr_pkg::data_t   irr,
   input  epu_isa_pkg::commit_t commit,
   output epu_isa_pkg::wb_t     wb
);

   epu_isa_pkg::msr_addr_t   addr;
   epu_msr_pkg::data_t       rdata;
   epu_msr_pkg::msr_view_t   view;
   epu_msr_pkg::msr_update_t upd;

   msr_decode #(
      .syscall_vector (syscall_vector),
      .eitm_vector    (eitm_vector),
      .eipf_vector    (eipf_vector),
      .einsn_vector   (einsn_vector),
      .eirq_vector    (eirq_vector)
   ) decode_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_pc    (issue_pc),
      .issue_op    (issue_op),
      .operand1    (operand1),
      .operand2    (operand2),
      .imm         (imm),
      .rdata       (rdata),
      .epc         (view.epc),
      .addr        (addr),
      .wb          (wb)
   );

   msr_readout #(.core_id(core_id)) readout_i (
      .addr  (addr),
      .view  (view),
      .irr   (irr),
      .rdata (rdata)
   );

   commit_unit commit_i (
      .commit (commit),
      .view   (view),
      .upd    (upd)
   );

   msr_file file_i (
      .clk   (clk),
      .rst_n (rst_n),
      .upd   (upd),
      .view  (view)
   );

endmodule

// ==== verilog/msr_file.sv ====
/*
 * MSR register file
 * PSR, EPSR, EPC, ELSA, IMR, TSR and TCR with load enables
 */

`timescale 1ns/1ns

module msr_file (
   input  logic                     clk,
   input  logic                     rst_n,
   input  epu_msr_pkg::msr_update_t upd,
   output epu_msr_pkg::msr_view_t   view
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         view.psr  <= epu_msr_pkg::psr_reset;
         view.epsr <= '0;
         view.epc  <= '0;
         view.elsa <= '0;
         view.imr  <= '0;
         view.tsr  <= '0;
         view.tcr  <= '0;
      end else begin
         if (upd.psr.we) begin
            view.psr <= upd.psr.nxt;
         end
         if (upd.epsr.we) begin
            view.epsr <= upd.epsr.nxt;
         end
         if (upd.epc.we) begin
            view.epc <= upd.epc.nxt;
         end
         if (upd.elsa.we) begin
            view.elsa <= upd.elsa.nxt;
         end
         // Interrupt mask
         if (upd.imr.we) begin
            view.imr <= upd.imr.nxt;
         end
         // Timer registers, loaded by software only
         if (upd.tsr.we) begin
            view.tsr <= upd.tsr.nxt;
         end
         if (upd.tcr.we) begin
            view.tcr <= upd.tcr.nxt;
         end
      end
   end

endmodule

// ==== verilog/commit_unit.sv ====
/*
 * Commit-side MSR update logic
 * Exception entry, PSR restore on return
 * EPC link address and ELSA source selection
 */

`timescale 1ns/1ns

module commit_unit (
   input  epu_isa_pkg::commit_t     commit,
   input  epu_msr_pkg::msr_view_t   view,
   output epu_msr_pkg::msr_update_t upd
);

   epu_msr_pkg::msr_we_t wr;
   epu_msr_pkg::psr_t    wpsr;
   epu_msr_pkg::psr_t    psr_src;
   epu_msr_pkg::pc_t     linkaddr;
   logic                 exc_ret;
   logic                 exc_ent;
   logic                 elsa_as_pc;
   logic                 elsa_as_lsa;

   assign wr   = commit.valid ? commit.wmsr_we : '0;
   assign wpsr = epu_msr_pkg::psr_t'(commit.wmsr_dat[$bits(epu_msr_pkg::psr_t)-1:0]);

   assign exc_ret = commit.valid && commit.exc == epu_isa_pkg::exc_eret;
   assign exc_ent = commit.valid && commit.exc != epu_isa_pkg::exc_none && !exc_ret;

   // PSR mode bits come from the written data or from EPSR on return
   assign psr_src = wr.psr ? wpsr : view.epsr;

   always_comb begin
      upd.psr.we       = wr.psr || exc_ret;
      upd.psr.nxt      = view.psr;
      upd.psr.nxt.rm   = psr_src.rm;
      upd.psr.nxt.ire  = psr_src.ire;
      upd.psr.nxt.imme = psr_src.imme;
      upd.psr.nxt.dmme = psr_src.dmme;
   end

   // Save the PSR as it was before entry
   assign upd.epsr.we  = wr.epsr || exc_ent;
   assign upd.epsr.nxt = wr.epsr ? wpsr : view.psr;

   // Syscall returns to the next instruction
   assign linkaddr    = commit.pc + 30'd1;
   assign upd.epc.we  = wr.epc || exc_ent;
   assign upd.epc.nxt = wr.epc ? commit.wmsr_dat :
                        commit.exc == epu_isa_pkg::exc_syscall ? {linkaddr, 2'b00} :
                        {commit.pc, 2'b00};

   // Fetch-side faults record the pc, data-side faults the access address
   assign elsa_as_pc  = commit.valid && (commit.exc == epu_isa_pkg::exc_eitm ||
                                         commit.exc == epu_isa_pkg::exc_eipf ||
                                         commit.exc == epu_isa_pkg::exc_einsn);
   assign elsa_as_lsa = commit.valid && (commit.exc == epu_isa_pkg::exc_edtm ||
                                         commit.exc == epu_isa_pkg::exc_edpf ||
                                         commit.exc == epu_isa_pkg::exc_ealign);
   assign upd.elsa.we  = elsa_as_pc || elsa_as_lsa || wr.elsa;
   assign upd.elsa.nxt = elsa_as_pc  ? {commit.pc, 2'b00} :
                         elsa_as_lsa ? commit.lsa : commit.wmsr_dat;

   assign upd.imr.we  = wr.imr;
   assign upd.imr.nxt = commit.wmsr_dat;
   assign upd.tsr.we  = wr.tsr;
   assign upd.tsr.nxt = commit.wmsr_dat;
   assign upd.tcr.we  = wr.tcr;
   assign upd.tcr.nxt = commit.wmsr_dat;

endmodule

// ==== verilog/msr_readout.sv ====
/*
 * MSR read multiplexer
 * Per-bank OR of the registers selected by the one-hot offset
 */

`timescale 1ns/1ns

module msr_readout #(
   parameter epu_msr_pkg::data_t core_id = 32'h0000_0000
) (
   input  epu_isa_pkg::msr_addr_t addr,
   input  epu_msr_pkg::msr_view_t view,
   input  epu_msr_pkg::data_t     irr,
   output epu_msr_pkg::data_t     rdata
);

   localparam int pad_w = $bits(epu_msr_pkg::data_t) - $bits(epu_msr_pkg::psr_t);

   epu_isa_pkg::msr_bank_e bank;
   epu_isa_pkg::msr_off_t  off;
   epu_msr_pkg::data_t     dout_ps;
   epu_msr_pkg::data_t     dout_irqc;
   epu_msr_pkg::data_t     dout_tsc;

   assign bank = epu_isa_pkg::msr_bank_e'(addr[12:9]);
   assign off  = addr[8:0];

   // PSR and EPSR are narrow, upper bits read as zero
   assign dout_ps =
      ({32{off[epu_isa_pkg::off_psr]}}    & {{pad_w{1'b0}}, view.psr}) |
      ({32{off[epu_isa_pkg::off_cpuid]}}  & epu_msr_pkg::cpuid_value) |
      ({32{off[epu_isa_pkg::off_epsr]}}   & {{pad_w{1'b0}}, view.epsr}) |
      ({32{off[epu_isa_pkg::off_epc]}}    & view.epc) |
      ({32{off[epu_isa_pkg::off_elsa]}}   & view.elsa) |
      ({32{off[epu_isa_pkg::off_coreid]}} & core_id);

   assign dout_irqc =
      ({32{off[epu_isa_pkg::off_imr]}} & view.imr) |
      ({32{off[epu_isa_pkg::off_irr]}} & irr);

   assign dout_tsc =
      ({32{off[epu_isa_pkg::off_tsr]}} & view.tsr) |
      ({32{off[epu_isa_pkg::off_tcr]}} & view.tcr);

   always_comb begin
      case (bank)
         epu_isa_pkg::bank_ps:   rdata = dout_ps;
         epu_isa_pkg::bank_irqc: rdata = dout_irqc;
         epu_isa_pkg::bank_tsc:  rdata = dout_tsc;
         default:                rdata = '0;
      endcase
   end

endmodule

// ==== verilog/msr_decode.sv ====
/*
 * Issue-side decode of EPU operations
 * MSR address, write enables, trap kind and vector
 * Writeback register
 */

`timescale 1ns/1ns

module msr_decode #(
   parameter epu_msr_pkg::data_t syscall_vector = 32'h0000_0100,
   parameter epu_msr_pkg::data_t eitm_vector    = 32'h0000_0200,
   parameter epu_msr_pkg::data_t eipf_vector    = 32'h0000_0300,
   parameter epu_msr_pkg::data_t einsn_vector   = 32'h0000_0400,
   parameter epu_msr_pkg::data_t eirq_vector    = 32'h0000_0500
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue_valid,
   input  epu_msr_pkg::pc_t      issue_pc,
   input  epu_isa_pkg::epu_op_e  issue_op,
   input  epu_msr_pkg::data_t    operand1,
   input  epu_msr_pkg::data_t    operand2,
   input  epu_msr_pkg::data_t    imm,
   input  epu_msr_pkg::data_t    rdata,
   input  epu_msr_pkg::data_t    epc,
   output epu_isa_pkg::msr_addr_t addr,
   output epu_isa_pkg::wb_t      wb
);

   epu_isa_pkg::msr_bank_e bank;
   epu_isa_pkg::msr_off_t  off;
   logic                   wmsr;
   epu_isa_pkg::wb_t       wb_nxt;

   assign addr = operand1[12:0] | imm[12:0];
   assign bank = epu_isa_pkg::msr_bank_e'(addr[12:9]);
   assign off  = addr[8:0];
   assign wmsr = issue_valid && (issue_op == epu_isa_pkg::op_wmsr);

   always_comb begin
      wb_nxt          = '0;
      wb_nxt.valid    = issue_valid;
      wb_nxt.pc       = issue_pc;
      wb_nxt.wmsr_dat = operand2;
      if (issue_op == epu_isa_pkg::op_rmsr) begin
         wb_nxt.dout = rdata;
      end

      // Trap kind and target, vectors are word aligned
      if (issue_valid) begin
         case (issue_op)
            epu_isa_pkg::op_syscall: begin
               wb_nxt.exc     = epu_isa_pkg::exc_syscall;
               wb_nxt.exc_vec = syscall_vector[31:2];
            end
            epu_isa_pkg::op_eret: begin
               wb_nxt.exc     = epu_isa_pkg::exc_eret;
               wb_nxt.exc_vec = epc[31:2];
            end
            epu_isa_pkg::op_eitm: begin
               wb_nxt.exc     = epu_isa_pkg::exc_eitm;
               wb_nxt.exc_vec = eitm_vector[31:2];
            end
            epu_isa_pkg::op_eipf: begin
               wb_nxt.exc     = epu_isa_pkg::exc_eipf;
               wb_nxt.exc_vec = eipf_vector[31:2];
            end
            epu_isa_pkg::op_eirq: begin
               wb_nxt.exc     = epu_isa_pkg::exc_eirq;
               wb_nxt.exc_vec = eirq_vector[31:2];
            end
            epu_isa_pkg::op_einsn: begin
               wb_nxt.exc     = epu_isa_pkg::exc_einsn;
               wb_nxt.exc_vec = einsn_vector[31:2];
            end
            default: wb_nxt.exc = epu_isa_pkg::exc_none;
         endcase
      end

      // Only writable registers get an enable
      wb_nxt.wmsr_we.psr  = wmsr && bank == epu_isa_pkg::bank_ps && off[epu_isa_pkg::off_psr];
      wb_nxt.wmsr_we.epc  = wmsr && bank == epu_isa_pkg::bank_ps && off[epu_isa_pkg::off_epc];
      wb_nxt.wmsr_we.epsr = wmsr && bank == epu_isa_pkg::bank_ps && off[epu_isa_pkg::off_epsr];
      wb_nxt.wmsr_we.elsa = wmsr && bank == epu_isa_pkg::bank_ps && off[epu_isa_pkg::off_elsa];
      wb_nxt.wmsr_we.imr  = wmsr && bank == epu_isa_pkg::bank_irqc && off[epu_isa_pkg::off_imr];
      wb_nxt.wmsr_we.tsr  = wmsr && bank == epu_isa_pkg::bank_tsc && off[epu_isa_pkg::off_tsr];
      wb_nxt.wmsr_we.tcr  = wmsr && bank == epu_isa_pkg::bank_tsc && off[epu_isa_pkg::off_tcr];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb <= '0;
      end else begin
         wb <= wb_nxt;
      end
   end

endmodule

// ==== verilog/epu_isa_pkg.sv ====
/*
 * EPU operation and exception kind encodings
 * MSR bank numbers, offset bits and address type
 * Writeback and commit records
 */

package epu_isa_pkg;

   typedef enum logic [2:0] {
      op_rmsr, op_wmsr, op_syscall, op_eret, op_eitm, op_eipf, op_eirq, op_einsn
   } epu_op_e;

   typedef enum logic [3:0] {
      exc_none, exc_syscall, exc_eret, exc_eitm, exc_eipf, exc_einsn, exc_eirq,
      exc_edtm, exc_edpf, exc_ealign
   } exc_kind_e;

   typedef enum logic [3:0] {
      bank_ps   = 4'd0,
      bank_irqc = 4'd6,
      bank_tsc  = 4'd7
   } msr_bank_e;

   // Bank in bits 12..9, one-hot offset in bits 8..0
   typedef logic [12:0] msr_addr_t;
   typedef logic [8:0]  msr_off_t;

   // PS bank
   localparam int off_psr    = 0;
   localparam int off_cpuid  = 1;
   localparam int off_epsr   = 2;
   localparam int off_epc    = 3;
   localparam int off_elsa   = 4;
   localparam int off_coreid = 5;
   // IRQC bank
   localparam int off_imr = 0;
   localparam int off_irr = 1;
   // TSC bank
   localparam int off_tsr = 0;
   localparam int off_tcr = 1;

   typedef struct packed {
      logic                 valid;
      epu_msr_pkg::pc_t     pc;
      epu_msr_pkg::data_t   dout;
      exc_kind_e            exc;
      epu_msr_pkg::pc_t     exc_vec;
      epu_msr_pkg::msr_we_t wmsr_we;
      epu_msr_pkg::data_t   wmsr_dat;
   } wb_t;

   typedef struct packed {
      logic                 valid;
      epu_msr_pkg::pc_t     pc;
      exc_kind_e            exc;
      epu_msr_pkg::msr_we_t wmsr_we;
      epu_msr_pkg::data_t   wmsr_dat;
      epu_msr_pkg::data_t   lsa;
   } commit_t;

endpackage

// ==== verilog/epu_msr_pkg.sv ====
/*
 * MSR data types
 * Data word, word address and CPU identifier
 * PSR layout and its reset value
 * Write-enable set, MSR view and update records
 */

package epu_msr_pkg;

   typedef logic [31:0] data_t;

   // Word address, byte address bits 31..2
   typedef logic [29:0] pc_t;

   localparam data_t cpuid_value = 32'h0001_0032;

   typedef struct packed {
      logic [1:0] res_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] res_lo;
   } psr_t;

   // Supervisor mode, MMUs and interrupts off
   localparam psr_t psr_reset = '{res_hi: 2'b00, dmme: 1'b0, imme: 1'b0, ire: 1'b0,
                                  rm: 1'b1, res_lo: 4'h0};

   typedef struct packed {
      logic psr;
      logic epc;
      logic epsr;
      logic elsa;
      logic imr;
      logic tsr;
      logic tcr;
   } msr_we_t;

   typedef struct packed {
      psr_t  psr;
      psr_t  epsr;
      data_t epc;
      data_t elsa;
      data_t imr;
      data_t tsr;
      data_t tcr;
   } msr_view_t;

   typedef struct packed {
      logic we;
      psr_t nxt;
   } psr_upd_t;

   typedef struct packed {
      logic  we;
      data_t nxt;
   } data_upd_t;

   typedef struct packed {
      psr_upd_t  psr;
      psr_upd_t  epsr;
      data_upd_t epc;
      data_upd_t elsa;
      data_upd_t imr;
      data_upd_t tsr;
      data_upd_t tcr;
   } msr_update_t;

endpackage
